// ==== flist.f ====
+incdir+src
src/mips_mem_pkg.sv
src/line_ram.sv
src/mmio_devs.sv
src/l1mmu.sv
src/mmu_arbiter.sv
src/lsu_align.sv
src/mem_top.sv
verif/mem_sva.sv
verif/mem_tb.sv

// ==== src/l1mmu.sv ====
`timescale 1ns/1ps
`include "mips_mem_config.svh"

module l1mmu (
    input  logic                          sys_clk,
    input  logic                          rst_n,
    input  logic                          mmu_req,
    input  logic                          mmu_write,
    input  mips_mem_pkg::addr_t           mmu_addr,
    input  mips_mem_pkg::line_t           mmu_wline,
    output logic                          mmu_ack,
    output mips_mem_pkg::line_t           mmu_rline,
    output logic                          ram_en,
    output logic                          ram_we,
    output logic [$clog2(`RAM_LINES)-1:0] ram_index,
    output mips_mem_pkg::line_t           ram_wline,
    input  mips_mem_pkg::line_t           ram_rline,
    output logic                          mmio_req,
    output logic                          mmio_write,
    output mips_mem_pkg::addr_t           mmio_addr,
    output mips_mem_pkg::word_t           mmio_wdata,
    input  logic                          mmio_ack,
    input  mips_mem_pkg::word_t           mmio_rdata
);
    import mips_mem_pkg::*;

    localparam int IDX_W = $clog2(`RAM_LINES);

    mmu_state_t state;
    logic       is_io;
    logic [2:0] lane;
    line_t      io_line;

    assign is_io = (mmu_addr >= `MMIO_BASE);
    assign lane  = mmu_addr[4:2];

    // request fields are held by the arbiter for the whole access
    assign ram_we     = mmu_write;
    assign ram_index  = mmu_addr[5 +: IDX_W];
    assign ram_wline  = mmu_wline;
    assign mmio_write = mmu_write;
    assign mmio_addr  = {mmu_addr[31:2], 2'b00};
    assign mmio_wdata = mmu_wline[lane*32 +: 32];

    // device word lands in its lane, rest zero
    always_comb begin
        io_line = '0;
        io_line[lane*32 +: 32] = mmio_rdata;
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= MMU_IDLE;
            mmu_ack  <= 1'b0;
            ram_en   <= 1'b0;
            mmio_req <= 1'b0;
        end else begin
            case (state)
                MMU_IDLE: begin
                    if (mmu_req) begin
                        if (is_io) begin
                            mmio_req <= 1'b1;
                            state    <= MMU_IO_ACC;
                        end else begin
                            ram_en <= 1'b1;
                            state  <= MMU_RAM_ACC;
                        end
                    end
                end
                MMU_RAM_ACC: begin
                    // one cycle of ram_en, then data is there
                    if (ram_en) begin
                        ram_en <= 1'b0;
                    end else begin
                        mmu_ack <= 1'b1;
                        state   <= MMU_ACK;
                    end
                end
                MMU_IO_ACC: begin
                    if (mmio_req && mmio_ack) begin
                        mmio_req <= 1'b0;
                    end else if (!mmio_req && !mmio_ack) begin
                        mmu_ack <= 1'b1;
                        state   <= MMU_ACK;
                    end
                end
                MMU_ACK: begin
                    if (!mmu_req) begin
                        mmu_ack <= 1'b0;
                        state   <= MMU_IDLE;
                    end
                end
                default: state <= MMU_IDLE;
            endcase
        end
    end

    // result capture, held through ack
    always_ff @(posedge sys_clk) begin
        if (state == MMU_RAM_ACC && !ram_en) begin
            mmu_rline <= ram_rline;
        end else if (state == MMU_IO_ACC && mmio_req && mmio_ack) begin
            mmu_rline <= io_line;
        end
    end

endmodule

// ==== src/line_ram.sv ====
`timescale 1ns/1ps
`include "mips_mem_config.svh"

module line_ram (
    input  logic                           sys_clk,
    input  logic                           ram_en,
    input  logic                           ram_we,
    input  logic [$clog2(`RAM_LINES)-1:0]  ram_index,
    input  mips_mem_pkg::line_t            ram_wline,
    output mips_mem_pkg::line_t            ram_rline
);
    import mips_mem_pkg::*;

    line_t mem [`RAM_LINES];

    // registered read, write returns the new line
    always_ff @(posedge sys_clk) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[ram_index] <= ram_wline;
                ram_rline      <= ram_wline;
            end else begin
                ram_rline <= mem[ram_index];
            end
        end
    end

endmodule

// ==== src/lsu_align.sv ====
`timescale 1ns/1ps

module lsu_align (
    input  logic                 sys_clk,
    input  logic                 rst_n,
    input  logic                 ls_req,
    input  logic                 ls_write,
    input  mips_mem_pkg::ls_op_t ls_op,
    input  mips_mem_pkg::addr_t  ls_addr,
    input  mips_mem_pkg::word_t  ls_wdata,
    output logic                 ls_ack,
    output mips_mem_pkg::word_t  ls_rdata,
    output logic                 dl_req,
    output logic                 dl_write,
    output mips_mem_pkg::addr_t  dl_addr,
    output mips_mem_pkg::line_t  dl_wline,
    input  logic                 dl_ack,
    input  mips_mem_pkg::line_t  dl_rline
);
    import mips_mem_pkg::*;

    lsu_state_t  state;
    line_t       line_q;
    logic [2:0]  lane;
    word_t       lane_word;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    word_t       load_val;
    word_t       merged_word;
    line_t       merged_line;

    assign lane = ls_addr[4:2];

    // word bits stay on the address so the MMU can pick an MMIO lane;
    // the RAM side ignores bits 4:0
    assign dl_addr  = {ls_addr[31:2], 2'b00};
    assign dl_wline = merged_line;

    always_comb begin
        lane_word = line_q[lane*32 +: 32];
        sel_byte  = lane_word[ls_addr[1:0]*8 +: 8];
        sel_half  = lane_word[ls_addr[1]*16 +: 16];
        case (ls_op)
            3'b000:  load_val = {{24{sel_byte[7]}}, sel_byte};
            3'b001:  load_val = {{16{sel_half[15]}}, sel_half};
            3'b011:  load_val = lane_word;
            3'b100:  load_val = {24'b0, sel_byte};
            3'b101:  load_val = {16'b0, sel_half};
            default: load_val = lane_word;
        endcase
    end

    // store merge into the lane just read
    always_comb begin
        merged_word = lane_word;
        case (ls_op[1:0])
            2'b00:   merged_word[ls_addr[1:0]*8 +: 8] = ls_wdata[7:0];
            2'b01:   merged_word[ls_addr[1]*16 +: 16] = ls_wdata[15:0];
            default: merged_word = ls_wdata;
        endcase
        merged_line = line_q;
        merged_line[lane*32 +: 32] = merged_word;
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= LS_IDLE;
            ls_ack   <= 1'b0;
            dl_req   <= 1'b0;
            dl_write <= 1'b0;
        end else begin
            case (state)
                LS_IDLE: begin
                    if (ls_req) begin
                        dl_req   <= 1'b1;
                        dl_write <= 1'b0;
                        state    <= LS_RD_REQ;
                    end
                end
                LS_RD_REQ: begin
                    if (dl_ack) begin
                        dl_req <= 1'b0;
                        state  <= LS_RD_WAIT;
                    end
                end
                LS_RD_WAIT: begin
                    // line port must return to idle first
                    if (!dl_ack) begin
                        if (ls_write) begin
                            dl_req   <= 1'b1;
                            dl_write <= 1'b1;
                            state    <= LS_WR_REQ;
                        end else begin
                            ls_ack <= 1'b1;
                            state  <= LS_DONE;
                        end
                    end
                end
                LS_WR_REQ: begin
                    if (dl_ack) begin
                        dl_req <= 1'b0;
                        state  <= LS_WR_WAIT;
                    end
                end
                LS_WR_WAIT: begin
                    if (!dl_ack) begin
                        dl_write <= 1'b0;
                        ls_ack   <= 1'b1;
                        state    <= LS_DONE;
                    end
                end
                LS_DONE: begin
                    if (!ls_req) begin
                        ls_ack <= 1'b0;
                        state  <= LS_IDLE;
                    end
                end
                default: state <= LS_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == LS_RD_REQ && dl_ack) begin
            line_q <= dl_rline;
        end
        // load result held through ls_ack
        if (state == LS_RD_WAIT && !dl_ack && !ls_write) begin
            ls_rdata <= load_val;
        end
    end

endmodule

// ==== src/mem_top.sv ====
`timescale 1ns/1ps
`include "mips_mem_config.svh"

module mem_top (
    input  logic                 sys_clk,
    input  logic                 rst_n,

    // CPU data port
    input  logic                 ls_req,
    input  logic                 ls_write,
    input  mips_mem_pkg::ls_op_t ls_op,
    input  mips_mem_pkg::addr_t  ls_addr,
    input  mips_mem_pkg::word_t  ls_wdata,
    output logic                 ls_ack,
    output mips_mem_pkg::word_t  ls_rdata,

    // icache refill stand-in
    input  logic                 fetch_req,
    input  mips_mem_pkg::addr_t  fetch_addr,
    output logic                 fetch_ack,
    output mips_mem_pkg::line_t  fetch_line,

    input  logic [23:0]          switches_pin,
    output logic [23:0]          leds_pin
);
    import mips_mem_pkg::*;

    logic  dl_req;
    logic  dl_write;
    addr_t dl_addr;
    line_t dl_wline;
    logic  dl_ack;
    line_t dl_rline;

    logic  mmu_req;
    logic  mmu_write;
    addr_t mmu_addr;
    line_t mmu_wline;
    logic  mmu_ack;
    line_t mmu_rline;

    logic                          ram_en;
    logic                          ram_we;
    logic [$clog2(`RAM_LINES)-1:0] ram_index;
    line_t                         ram_wline;
    line_t                         ram_rline;

    logic  mmio_req;
    logic  mmio_write;
    addr_t mmio_addr;
    word_t mmio_wdata;
    logic  mmio_ack;
    word_t mmio_rdata;

    lsu_align u_lsu (
        .sys_clk(sys_clk),
        .rst_n(rst_n),
        .ls_req(ls_req),
        .ls_write(ls_write),
        .ls_op(ls_op),
        .ls_addr(ls_addr),
        .ls_wdata(ls_wdata),
        .ls_ack(ls_ack),
        .ls_rdata(ls_rdata),
        .dl_req(dl_req),
        .dl_write(dl_write),
        .dl_addr(dl_addr),
        .dl_wline(dl_wline),
        .dl_ack(dl_ack),
        .dl_rline(dl_rline)
    );

    mmu_arbiter u_arb (
        .sys_clk(sys_clk),
        .rst_n(rst_n),
        .fetch_req(fetch_req),
        .fetch_addr(fetch_addr),
        .fetch_ack(fetch_ack),
        .fetch_line(fetch_line),
        .dl_req(dl_req),
        .dl_write(dl_write),
        .dl_addr(dl_addr),
        .dl_wline(dl_wline),
        .dl_ack(dl_ack),
        .dl_rline(dl_rline),
        .mmu_req(mmu_req),
        .mmu_write(mmu_write),
        .mmu_addr(mmu_addr),
        .mmu_wline(mmu_wline),
        .mmu_ack(mmu_ack),
        .mmu_rline(mmu_rline)
    );

    l1mmu u_mmu (
        .sys_clk(sys_clk),
        .rst_n(rst_n),
        .mmu_req(mmu_req),
        .mmu_write(mmu_write),
        .mmu_addr(mmu_addr),
        .mmu_wline(mmu_wline),
        .mmu_ack(mmu_ack),
        .mmu_rline(mmu_rline),
        .ram_en(ram_en),
        .ram_we(ram_we),
        .ram_index(ram_index),
        .ram_wline(ram_wline),
        .ram_rline(ram_rline),
        .mmio_req(mmio_req),
        .mmio_write(mmio_write),
        .mmio_addr(mmio_addr),
        .mmio_wdata(mmio_wdata),
        .mmio_ack(mmio_ack),
        .mmio_rdata(mmio_rdata)
    );

    line_ram u_ram (
        .sys_clk(sys_clk),
        .ram_en(ram_en),
        .ram_we(ram_we),
        .ram_index(ram_index),
        .ram_wline(ram_wline),
        .ram_rline(ram_rline)
    );

    mmio_devs u_io (
        .sys_clk(sys_clk),
        .rst_n(rst_n),
        .mmio_req(mmio_req),
        .mmio_write(mmio_write),
        .mmio_addr(mmio_addr),
        .mmio_wdata(mmio_wdata),
        .mmio_ack(mmio_ack),
        .mmio_rdata(mmio_rdata),
        .switches_pin(switches_pin),
        .leds_pin(leds_pin)
    );

endmodule

// ==== src/mips_mem_config.svh ====
`ifndef MIPS_MEM_CONFIG_SVH
`define MIPS_MEM_CONFIG_SVH

// one cache line is 8 words
`define LINE_BITS 256

// 16 lines, byte addresses 0..511, aliased above
`define RAM_LINES 16

// everything at or above this is device space
`define MMIO_BASE 32'hffff0000

// device register offsets from MMIO_BASE
`define MMIO_SWITCH_OFS 0
`define MMIO_LED_OFS 4

`endif

// ==== src/mips_mem_pkg.sv ====
`include "mips_mem_config.svh"

package mips_mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [`LINE_BITS-1:0] line_t;

    // 000 lb, 001 lh, 011 lw, 100 lbu, 101 lhu
    // stores use [1:0] as size
    typedef logic [2:0] ls_op_t;

    typedef enum logic [2:0] {
        LS_IDLE,
        LS_RD_REQ,
        LS_RD_WAIT,
        LS_WR_REQ,
        LS_WR_WAIT,
        LS_DONE
    } lsu_state_t;

    typedef enum logic [1:0] {
        MMU_IDLE,
        MMU_RAM_ACC,
        MMU_IO_ACC,
        MMU_ACK
    } mmu_state_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FETCH,
        ARB_DATA
    } arb_state_t;

endpackage

// ==== src/mmio_devs.sv ====
`timescale 1ns/1ps
`include "mips_mem_config.svh"

module mmio_devs (
    input  logic                sys_clk,
    input  logic                rst_n,
    input  logic                mmio_req,
    input  logic                mmio_write,
    input  mips_mem_pkg::addr_t mmio_addr,
    input  mips_mem_pkg::word_t mmio_wdata,
    output logic                mmio_ack,
    output mips_mem_pkg::word_t mmio_rdata,
    input  logic [23:0]         switches_pin,
    output logic [23:0]         leds_pin
);
    import mips_mem_pkg::*;

    logic [23:0] sw_q;
    logic [23:0] led_q;
    word_t       ofs;
    word_t       rd_val;

    assign ofs      = mmio_addr - `MMIO_BASE;
    assign leds_pin = led_q;

    always_comb begin
        case (ofs)
            `MMIO_SWITCH_OFS: rd_val = {8'b0, sw_q};
            `MMIO_LED_OFS:    rd_val = {8'b0, led_q};
            default:          rd_val = '0;
        endcase
    end

    // free-running switch sample
    always_ff @(posedge sys_clk) begin
        sw_q <= switches_pin;
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            mmio_ack <= 1'b0;
            led_q    <= '0;
        end else if (mmio_req && !mmio_ack) begin
            mmio_ack <= 1'b1;
            // switch writes fall through
            if (mmio_write && ofs == `MMIO_LED_OFS) begin
                led_q <= mmio_wdata[23:0];
            end
        end else if (!mmio_req) begin
            mmio_ack <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (mmio_req && !mmio_ack) begin
            mmio_rdata <= rd_val;
        end
    end

endmodule

// ==== src/mmu_arbiter.sv ====
`timescale 1ns/1ps

module mmu_arbiter (
    input  logic                sys_clk,
    input  logic                rst_n,
    input  logic                fetch_req,
    input  mips_mem_pkg::addr_t fetch_addr,
    output logic                fetch_ack,
    output mips_mem_pkg::line_t fetch_line,
    input  logic                dl_req,
    input  logic                dl_write,
    input  mips_mem_pkg::addr_t dl_addr,
    input  mips_mem_pkg::line_t dl_wline,
    output logic                dl_ack,
    output mips_mem_pkg::line_t dl_rline,
    output logic                mmu_req,
    output logic                mmu_write,
    output mips_mem_pkg::addr_t mmu_addr,
    output mips_mem_pkg::line_t mmu_wline,
    input  logic                mmu_ack,
    input  mips_mem_pkg::line_t mmu_rline
);
    import mips_mem_pkg::*;

    arb_state_t state;
    logic       owner_req;

    assign owner_req = (state == ARB_FETCH) ? fetch_req : dl_req;

    // ack and line go back to the owner only
    assign fetch_ack  = (state == ARB_FETCH) && mmu_ack;
    assign dl_ack     = (state == ARB_DATA) && mmu_ack;
    assign fetch_line = (state == ARB_FETCH) ? mmu_rline : '0;
    assign dl_rline   = (state == ARB_DATA) ? mmu_rline : '0;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ARB_IDLE;
            mmu_req <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // fetch wins a tie, like serve_ic
                    if (fetch_req) begin
                        state   <= ARB_FETCH;
                        mmu_req <= 1'b1;
                    end else if (dl_req) begin
                        state   <= ARB_DATA;
                        mmu_req <= 1'b1;
                    end
                end
                ARB_FETCH, ARB_DATA: begin
                    if (mmu_req) begin
                        if (!owner_req) begin
                            mmu_req <= 1'b0;
                        end
                    end else if (!mmu_ack) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // request fields latched at grant
    always_ff @(posedge sys_clk) begin
        if (state == ARB_IDLE) begin
            if (fetch_req) begin
                mmu_write <= 1'b0;
                mmu_addr  <= fetch_addr;
            end else begin
                mmu_write <= dl_write;
                mmu_addr  <= dl_addr;
                mmu_wline <= dl_wline;
            end
        end
    end

endmodule

// ==== verif/mem_sva.sv ====
`timescale 1ns/1ps

module mem_sva (
    input logic sys_clk,
    input logic rst_n,
    input logic ls_req,
    input logic ls_ack,
    input logic fetch_req,
    input logic fetch_ack,
    input logic dl_req,
    input logic dl_ack,
    input logic mmu_req,
    input logic mmu_ack,
    input logic mmio_req,
    input logic mmio_ack
);
    int sva_errors = 0;

    ls_ack_needs_req: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $rose(ls_ack) |-> $past(ls_req))
        else begin
            $error("ls_ack rose without ls_req");
            sva_errors++;
        end

    // req may only drop once ack is seen
    ls_req_held: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $fell(ls_req) |-> ls_ack)
        else begin
            $error("ls_req dropped before ls_ack");
            sva_errors++;
        end

    fetch_ack_needs_req: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $rose(fetch_ack) |-> $past(fetch_req))
        else begin
            $error("fetch_ack rose without fetch_req");
            sva_errors++;
        end

    ack_falls_after_req: assert property (@(posedge sys_clk) disable iff (!rst_n)
        ($fell(ls_ack) |-> $past(!ls_req)) and ($fell(fetch_ack) |-> $past(!fetch_req))
        and ($fell(dl_ack) |-> $past(!dl_req)) and ($fell(mmu_ack) |-> $past(!mmu_req))
        and ($fell(mmio_ack) |-> $past(!mmio_req)))
        else begin
            $error("an ack fell while its req was still high");
            sva_errors++;
        end

endmodule

bind mem_top mem_sva u_sva (
    .sys_clk(sys_clk),
    .rst_n(rst_n),
    .ls_req(ls_req),
    .ls_ack(ls_ack),
    .fetch_req(fetch_req),
    .fetch_ack(fetch_ack),
    .dl_req(dl_req),
    .dl_ack(dl_ack),
    .mmu_req(mmu_req),
    .mmu_ack(mmu_ack),
    .mmio_req(mmio_req),
    .mmio_ack(mmio_ack)
);

// ==== verif/mem_tb.sv ====
`timescale 1ns/1ps
`include "mips_mem_config.svh"

module mem_tb;
    import mips_mem_pkg::*;

    localparam int N_FILL = 128;
    localparam int N_WORD = 40;
    localparam int N_SUB = 60;
    localparam int N_CONC = 16;
    localparam int N_LED = 8;
    localparam int N_SW = 8;
    localparam int STALL_LIMIT = 200;
    // stores cost two line accesses, loads and fetches one
    localparam int N_STORES = N_FILL + N_WORD + N_SUB + N_CONC + 2 * N_LED + N_SW;
    localparam int N_LOADS = N_WORD + N_SUB + 2 * N_LED + 2 * N_SW;
    localparam int N_FETCH = N_CONC + 8;
    localparam int TIMEOUT_CYCLES = 20 * (2 * N_STORES + N_LOADS + N_FETCH) + 4;
    localparam addr_t SW_ADDR = `MMIO_BASE + `MMIO_SWITCH_OFS;
    localparam addr_t LED_ADDR = `MMIO_BASE + `MMIO_LED_OFS;

    logic        sys_clk;
    logic        rst_n;
    logic        ls_req;
    logic        ls_write;
    ls_op_t      ls_op;
    addr_t       ls_addr;
    word_t       ls_wdata;
    logic        ls_ack;
    word_t       ls_rdata;
    logic        fetch_req;
    addr_t       fetch_addr;
    logic        fetch_ack;
    line_t       fetch_line;
    logic [23:0] switches_pin;
    logic [23:0] leds_pin;

    integer      seed;
    int          err_count;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;
    logic [7:0]  ram_model [512];
    logic [23:0] led_model;
    ls_op_t      load_ops [5] = '{3'b000, 3'b001, 3'b011, 3'b100, 3'b101};

    mem_top u_mem_top (
        .sys_clk(sys_clk),
        .rst_n(rst_n),
        .ls_req(ls_req),
        .ls_write(ls_write),
        .ls_op(ls_op),
        .ls_addr(ls_addr),
        .ls_wdata(ls_wdata),
        .ls_ack(ls_ack),
        .ls_rdata(ls_rdata),
        .fetch_req(fetch_req),
        .fetch_addr(fetch_addr),
        .fetch_ack(fetch_ack),
        .fetch_line(fetch_line),
        .switches_pin(switches_pin),
        .leds_pin(leds_pin)
    );

    always #50 sys_clk = ~sys_clk;

    // little endian word from the byte model
    function automatic word_t model_word(input int a);
        int base;
        base = a & 'h1fc;
        return {ram_model[base + 3], ram_model[base + 2], ram_model[base + 1], ram_model[base]};
    endfunction

    function automatic word_t expect_load(input word_t w, input ls_op_t op, input logic [1:0] lo);
        logic [7:0]  b;
        logic [15:0] h;
        b = w >> (8 * lo);
        h = lo[1] ? w[31:16] : w[15:0];
        case (op)
            3'b000:  return {{24{b[7]}}, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b100:  return {24'b0, b};
            3'b101:  return {16'b0, h};
            default: return w;
        endcase
    endfunction

    task automatic store_model(input int a, input ls_op_t op, input word_t wd);
        int base;
        base = a & 'h1ff;
        case (op[1:0])
            2'b00: ram_model[base] = wd[7:0];
            2'b01: begin
                ram_model[base & ~1] = wd[7:0];
                ram_model[(base & ~1) + 1] = wd[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    ram_model[(base & ~3) + i] = wd[8 * i +: 8];
                end
            end
        endcase
    endtask

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_line(input string name, input int a, input line_t ln);
        for (int k = 0; k < 8; k++) begin
            check(name, model_word((a & 'h1e0) + 4 * k), ln[32 * k +: 32]);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic cpu_access(input logic wr, input ls_op_t op, input addr_t a,
                              input word_t wd, output word_t rd);
        int n;
        @(negedge sys_clk);
        ls_req = 1'b1;
        ls_write = wr;
        ls_op = op;
        ls_addr = a;
        ls_wdata = wd;
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
        end while (!ls_ack && n < STALL_LIMIT);
        if (!ls_ack) begin
            $display("data port access to %h got no ls_ack within %0d cycles", a, n);
            err_count++;
        end
        rd = ls_rdata;
        ls_req = 1'b0;
        n = 0;
        while (ls_ack && n < STALL_LIMIT) begin
            @(negedge sys_clk);
            n++;
        end
        if (ls_ack) begin
            $display("ls_ack stayed high after ls_req dropped");
            err_count++;
        end
    endtask

    task automatic fetch_read(input addr_t a, output line_t ln);
        int n;
        @(negedge sys_clk);
        fetch_req = 1'b1;
        fetch_addr = a;
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
        end while (!fetch_ack && n < STALL_LIMIT);
        if (!fetch_ack) begin
            $display("fetch of %h got no fetch_ack within %0d cycles", a, n);
            err_count++;
        end
        ln = fetch_line;
        fetch_req = 1'b0;
        n = 0;
        while (fetch_ack && n < STALL_LIMIT) begin
            @(negedge sys_clk);
            n++;
        end
        if (fetch_ack) begin
            $display("fetch_ack stayed high after fetch_req dropped");
            err_count++;
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge sys_clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles, handshakes did not finish", cycle_count);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        word_t       rd;
        word_t       wd;
        addr_t       a;
        ls_op_t      op;
        line_t       ln;
        int          errs;
        logic [23:0] sw_val;
        seed = 32'h13f70783;
        sys_clk = 1'b0;
        rst_n = 1'b0;
        ls_req = 1'b0;
        ls_write = 1'b0;
        ls_op = '0;
        ls_addr = '0;
        ls_wdata = '0;
        fetch_req = 1'b0;
        fetch_addr = '0;
        switches_pin = '0;
        err_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        led_model = '0;
        repeat (4) @(negedge sys_clk);
        rst_n = 1'b1;

        errs = err_count;
        check("reset_ls_ack", 32'd0, {31'd0, ls_ack});
        check("reset_fetch_ack", 32'd0, {31'd0, fetch_ack});
        check("reset_leds", 32'd0, {8'd0, leds_pin});
        end_test("reset", errs);

        // every RAM word gets a defined value first
        errs = err_count;
        for (int i = 0; i < N_FILL; i++) begin
            wd = $random(seed);
            cpu_access(1'b1, 3'b011, i * 4, wd, rd);
            store_model(i * 4, 3'b011, wd);
        end
        for (int i = 0; i < N_WORD; i++) begin
            a = $random(seed) & 32'h1fc;
            wd = $random(seed);
            cpu_access(1'b1, 3'b011, a, wd, rd);
            store_model(a[8:0], 3'b011, wd);
            cpu_access(1'b0, 3'b011, a, 32'd0, rd);
            check("word_round_trip", model_word(a[8:0]), rd);
        end
        end_test("word_round_trip", errs);

        errs = err_count;
        for (int i = 0; i < N_SUB; i++) begin
            a = $random(seed) & 32'h1ff;
            op = ($random(seed) & 1) ? 3'b001 : 3'b000;
            wd = $random(seed);
            cpu_access(1'b1, op, a, wd, rd);
            store_model(a[8:0], op, wd);
            // load from the same word at any byte offset
            a[1:0] = $random(seed);
            op = load_ops[($random(seed) & 32'h7fffffff) % 5];
            cpu_access(1'b0, op, a, 32'd0, rd);
            check("sub_word", expect_load(model_word(a[8:0]), op, a[1:0]), rd);
        end
        end_test("sub_word", errs);

        // stores hit lines 0..7 while fetches read lines 8..15
        errs = err_count;
        fork
            begin
                word_t sd;
                addr_t sa;
                word_t srd;
                for (int i = 0; i < N_CONC; i++) begin
                    sa = $random(seed) & 32'hfc;
                    sd = $random(seed);
                    cpu_access(1'b1, 3'b011, sa, sd, srd);
                    store_model(sa[8:0], 3'b011, sd);
                end
            end
            begin
                addr_t fa;
                line_t fl;
                for (int i = 0; i < N_CONC; i++) begin
                    repeat ($random(seed) & 7) @(negedge sys_clk);
                    fa = (8 + ($random(seed) & 7)) * 32;
                    fetch_read(fa, fl);
                    check_line("concurrent_fetch", fa[8:0], fl);
                end
            end
        join
        for (int k = 0; k < 8; k++) begin
            fetch_read(k * 32, ln);
            check_line("concurrent_fetch", k * 32, ln);
        end
        end_test("concurrent_fetch", errs);

        errs = err_count;
        for (int i = 0; i < N_LED; i++) begin
            wd = $random(seed);
            cpu_access(1'b1, 3'b011, LED_ADDR, wd, rd);
            led_model = wd[23:0];
            check("led_word", {8'd0, led_model}, {8'd0, leds_pin});
            cpu_access(1'b0, 3'b011, LED_ADDR, 32'd0, rd);
            check("led_word", {8'd0, led_model}, rd);
            a = LED_ADDR + ($random(seed) & 3);
            wd = $random(seed);
            cpu_access(1'b1, 3'b000, a, wd, rd);
            // byte 3 lies above the 24 LED bits
            if (a[1:0] != 2'd3) begin
                led_model[8 * a[1:0] +: 8] = wd[7:0];
            end
            check("led_byte", {8'd0, led_model}, {8'd0, leds_pin});
            cpu_access(1'b0, 3'b011, LED_ADDR, 32'd0, rd);
            check("led_byte", {8'd0, led_model}, rd);
        end
        end_test("led_register", errs);

        errs = err_count;
        for (int i = 0; i < N_SW; i++) begin
            @(negedge sys_clk);
            sw_val = $random(seed);
            switches_pin = sw_val;
            repeat (2) @(negedge sys_clk);
            cpu_access(1'b0, 3'b011, SW_ADDR, 32'd0, rd);
            check("switch_read", {8'd0, sw_val}, rd);
            cpu_access(1'b1, 3'b011, SW_ADDR, $random(seed), rd);
            cpu_access(1'b0, 3'b011, SW_ADDR, 32'd0, rd);
            check("switch_after_store", {8'd0, sw_val}, rd);
            check("switch_leds", {8'd0, led_model}, {8'd0, leds_pin});
        end
        end_test("switch_register", errs);

        if (u_mem_top.u_sva.sva_errors != 0) begin
            $display("handshake assertions failed %0d times", u_mem_top.u_sva.sva_errors);
            err_count++;
        end
        $display("tests passed %0d failed %0d, check errors %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
